// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_exec_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
logic/rv_exec_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/fu.sv
logic/exec_stage.sv
logic/rv_exec_top.sv
test/rv_exec_checker.sv
test/rv_exec_tb.sv

// File: logic/exec_stage.sv
module exec_stage (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         instr_valid_i,
  input  rv_exec_pkg::decoded_inst_t   dec_i,
  input  logic [rv_exec_pkg::XLEN-1:0] rdata1_i,
  input  logic [rv_exec_pkg::XLEN-1:0] rdata2_i,
  output rv_exec_pkg::ex_wb_t          wb_o
);

  rv_exec_pkg::id_ex_t          id_ex_q;
  rv_exec_pkg::ex_wb_t          ex_wb_q;
  logic                         fwd1;
  logic                         fwd2;
  logic [rv_exec_pkg::XLEN-1:0] op1_val;
  logic [rv_exec_pkg::XLEN-1:0] op2_val;
  logic [rv_exec_pkg::XLEN-1:0] alu_result;

  // decode/execute register.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q.valid  <= instr_valid_i && (dec_i.inst_type != rv_exec_pkg::INST_NOP);
      id_ex_q.dec    <= dec_i;
      id_ex_q.rdata1 <= rdata1_i;
      id_ex_q.rdata2 <= rdata2_i;
    end
  end

  // the previous instruction has not reached the register file yet,
  // so its result is taken straight from the writeback register.
  assign fwd1 = ex_wb_q.valid && (ex_wb_q.rd == id_ex_q.dec.rs1) &&
                (id_ex_q.dec.rs1 != '0);
  assign fwd2 = ex_wb_q.valid && (ex_wb_q.rd == id_ex_q.dec.rs2) &&
                (id_ex_q.dec.rs2 != '0);

  assign op1_val = fwd1 ? ex_wb_q.data : id_ex_q.rdata1;
  assign op2_val = fwd2 ? ex_wb_q.data : id_ex_q.rdata2;

  fu fu_inst (
    .inst_type_i  (id_ex_q.dec.inst_type),
    .alu_op_i     (id_ex_q.dec.alu_op),
    .pc_i         (id_ex_q.dec.pc),
    .imm_i        (id_ex_q.dec.imm),
    .rdata1_i     (op1_val),
    .rdata2_i     (op2_val),
    .alu_result_o (alu_result)
  );

  // execute/writeback register.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_wb_q <= '0;
    end else begin
      ex_wb_q.valid <= id_ex_q.valid;
      ex_wb_q.rd    <= id_ex_q.dec.rd;
      ex_wb_q.data  <= alu_result;
    end
  end

  assign wb_o = ex_wb_q;

endmodule

// File: logic/fu.sv
module fu (
  input  rv_exec_pkg::inst_type_e         inst_type_i,
  input  rv_exec_pkg::alu_op_e            alu_op_i,
  input  logic [rv_exec_pkg::XLEN-1:0]    pc_i,
  input  logic [rv_exec_pkg::XLEN-1:0]    imm_i,
  input  logic [rv_exec_pkg::XLEN-1:0]    rdata1_i,
  input  logic [rv_exec_pkg::XLEN-1:0]    rdata2_i,
  output logic [rv_exec_pkg::XLEN-1:0]    alu_result_o
);

  logic [rv_exec_pkg::XLEN-1:0] operand1;
  logic [rv_exec_pkg::XLEN-1:0] operand2;
  logic [4:0]                   shamt;
  logic                         is_nop;

  assign is_nop = (inst_type_i == rv_exec_pkg::INST_NOP) ||
                  (alu_op_i == rv_exec_pkg::ALU_OP_NOP);

  always_comb begin
    operand1 = '0;
    operand2 = '0;
    if (!is_nop) begin
      case (inst_type_i)
        rv_exec_pkg::INST_RR: begin
          operand1 = rdata1_i;
          operand2 = rdata2_i;
        end
        rv_exec_pkg::INST_RI: begin
          operand1 = rdata1_i;
          operand2 = imm_i;
        end
        rv_exec_pkg::INST_LUI:   operand2 = imm_i;
        rv_exec_pkg::INST_AUIPC: begin
          operand1 = pc_i;
          operand2 = imm_i;
        end
        rv_exec_pkg::INST_JAL:   operand1 = pc_i;
        rv_exec_pkg::INST_JALR:  operand1 = pc_i;
        default: ;
      endcase
    end
  end

  assign shamt = operand2[4:0];

  always_comb begin
    case (alu_op_i)
      rv_exec_pkg::ALU_OP_ADD:   alu_result_o = operand1 + operand2;
      rv_exec_pkg::ALU_OP_SUB:   alu_result_o = operand1 - operand2;
      rv_exec_pkg::ALU_OP_XOR:   alu_result_o = operand1 ^ operand2;
      rv_exec_pkg::ALU_OP_OR:    alu_result_o = operand1 | operand2;
      rv_exec_pkg::ALU_OP_AND:   alu_result_o = operand1 & operand2;
      rv_exec_pkg::ALU_OP_SLL:   alu_result_o = operand1 << shamt;
      rv_exec_pkg::ALU_OP_SRL:   alu_result_o = operand1 >> shamt;
      rv_exec_pkg::ALU_OP_SRA:   alu_result_o = $unsigned($signed(operand1) >>> shamt);
      rv_exec_pkg::ALU_OP_SLT:   alu_result_o = {31'd0, $signed(operand1) < $signed(operand2)};
      rv_exec_pkg::ALU_OP_SLTU:  alu_result_o = {31'd0, operand1 < operand2};
      rv_exec_pkg::ALU_OP_LUI:   alu_result_o = operand1 + operand2;
      rv_exec_pkg::ALU_OP_AUIPC: alu_result_o = operand1 + operand2;
      // link address for JAL and JALR.
      rv_exec_pkg::ALU_OP_JUMP:  alu_result_o = operand1 + 32'd4;
      default:                   alu_result_o = '0;
    endcase
    if (is_nop) begin
      alu_result_o = '0;
    end
  end

endmodule

// File: logic/inst_decoder.sv
module inst_decoder (
  input  logic [rv_exec_pkg::XLEN-1:0] instr_i,
  input  logic [rv_exec_pkg::XLEN-1:0] pc_i,
  output rv_exec_pkg::decoded_inst_t   dec_o
);

  logic [6:0]                   opcode;
  logic [2:0]                   funct3;
  logic                         funct7_b5;
  logic                         sub_sel;
  logic [rv_exec_pkg::XLEN-1:0] imm_i_type;
  logic [rv_exec_pkg::XLEN-1:0] imm_u_type;
  logic [rv_exec_pkg::XLEN-1:0] imm_j_type;
  rv_exec_pkg::alu_op_e         alu_op_arith;

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign funct7_b5 = instr_i[30];

  // bit 30 is part of the immediate for ADDI, so only OP may pick SUB.
  assign sub_sel = (opcode == rv_exec_pkg::OPC_OP) && funct7_b5;

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'h000};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  // ALU operation for the OP and OP-IMM classes.
  always_comb begin
    case (funct3)
      rv_exec_pkg::F3_ADD_SUB: begin
        alu_op_arith = sub_sel ? rv_exec_pkg::ALU_OP_SUB : rv_exec_pkg::ALU_OP_ADD;
      end
      rv_exec_pkg::F3_SLL:  alu_op_arith = rv_exec_pkg::ALU_OP_SLL;
      rv_exec_pkg::F3_SLT:  alu_op_arith = rv_exec_pkg::ALU_OP_SLT;
      rv_exec_pkg::F3_SLTU: alu_op_arith = rv_exec_pkg::ALU_OP_SLTU;
      rv_exec_pkg::F3_XOR:  alu_op_arith = rv_exec_pkg::ALU_OP_XOR;
      rv_exec_pkg::F3_SRL_SRA: begin
        alu_op_arith = funct7_b5 ? rv_exec_pkg::ALU_OP_SRA : rv_exec_pkg::ALU_OP_SRL;
      end
      rv_exec_pkg::F3_OR:   alu_op_arith = rv_exec_pkg::ALU_OP_OR;
      default:              alu_op_arith = rv_exec_pkg::ALU_OP_AND;
    endcase
  end

  always_comb begin
    dec_o.pc        = pc_i;
    dec_o.rd        = instr_i[11:7];
    dec_o.rs1       = instr_i[19:15];
    // rs2 stays zero unless the class reads it, so it never matches a forwarded rd.
    dec_o.rs2       = '0;
    dec_o.imm       = '0;
    dec_o.inst_type = rv_exec_pkg::INST_NOP;
    dec_o.alu_op    = rv_exec_pkg::ALU_OP_NOP;
    case (opcode)
      rv_exec_pkg::OPC_OP: begin
        dec_o.inst_type = rv_exec_pkg::INST_RR;
        dec_o.alu_op    = alu_op_arith;
        dec_o.rs2       = instr_i[24:20];
      end
      rv_exec_pkg::OPC_OP_IMM: begin
        dec_o.inst_type = rv_exec_pkg::INST_RI;
        dec_o.alu_op    = alu_op_arith;
        dec_o.imm       = imm_i_type;
      end
      rv_exec_pkg::OPC_LUI: begin
        dec_o.inst_type = rv_exec_pkg::INST_LUI;
        dec_o.alu_op    = rv_exec_pkg::ALU_OP_LUI;
        dec_o.rs1       = '0;
        dec_o.imm       = imm_u_type;
      end
      rv_exec_pkg::OPC_AUIPC: begin
        dec_o.inst_type = rv_exec_pkg::INST_AUIPC;
        dec_o.alu_op    = rv_exec_pkg::ALU_OP_AUIPC;
        dec_o.rs1       = '0;
        dec_o.imm       = imm_u_type;
      end
      rv_exec_pkg::OPC_JAL: begin
        dec_o.inst_type = rv_exec_pkg::INST_JAL;
        dec_o.alu_op    = rv_exec_pkg::ALU_OP_JUMP;
        dec_o.rs1       = '0;
        dec_o.imm       = imm_j_type;
      end
      rv_exec_pkg::OPC_JALR: begin
        dec_o.inst_type = rv_exec_pkg::INST_JALR;
        dec_o.alu_op    = rv_exec_pkg::ALU_OP_JUMP;
        dec_o.imm       = imm_i_type;
      end
      default: begin
        // loads, stores, branches, fences and system instructions retire silently.
        dec_o.rs1 = '0;
        dec_o.rd  = '0;
      end
    endcase
  end

endmodule

// File: logic/reg_file.sv
module reg_file (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic [rv_exec_pkg::REG_ADDR_W-1:0] raddr1_i,
  input  logic [rv_exec_pkg::REG_ADDR_W-1:0] raddr2_i,
  output logic [rv_exec_pkg::XLEN-1:0]       rdata1_o,
  output logic [rv_exec_pkg::XLEN-1:0]       rdata2_o,
  input  logic                               we_i,
  input  logic [rv_exec_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_exec_pkg::XLEN-1:0]       wdata_i
);

  // x0 has no storage.
  logic [rv_exec_pkg::XLEN-1:0] regs [1:31];
  logic                         wr_en;
  logic                         bypass1;
  logic                         bypass2;

  assign wr_en = we_i && (waddr_i != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // a read of the register being written this cycle sees the new value.
  assign bypass1 = wr_en && (raddr1_i == waddr_i);
  assign bypass2 = wr_en && (raddr2_i == waddr_i);

  assign rdata1_o = (raddr1_i == '0) ? '0      :
                    bypass1          ? wdata_i :
                                       regs[raddr1_i];

  assign rdata2_o = (raddr2_i == '0) ? '0      :
                    bypass2          ? wdata_i :
                                       regs[raddr2_i];

endmodule

// File: logic/rv_exec_pkg.sv
package rv_exec_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // major opcodes of the instruction classes the slice executes.
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // funct3 codes shared by OP and OP-IMM.
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  typedef enum logic [2:0] {
    INST_NOP,
    INST_RR,
    INST_RI,
    INST_LUI,
    INST_AUIPC,
    INST_JAL,
    INST_JALR
  } inst_type_e;

  typedef enum logic [3:0] {
    ALU_OP_NOP,
    ALU_OP_ADD,
    ALU_OP_SUB,
    ALU_OP_XOR,
    ALU_OP_OR,
    ALU_OP_AND,
    ALU_OP_SLL,
    ALU_OP_SRL,
    ALU_OP_SRA,
    ALU_OP_SLT,
    ALU_OP_SLTU,
    ALU_OP_LUI,
    ALU_OP_AUIPC,
    ALU_OP_JUMP
  } alu_op_e;

  typedef struct packed {
    inst_type_e            inst_type;
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
  } decoded_inst_t;

  typedef struct packed {
    logic            valid;
    decoded_inst_t   dec;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } ex_wb_t;

endpackage

// File: logic/rv_exec_top.sv
module rv_exec_top (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               instr_valid_i,
  input  logic [rv_exec_pkg::XLEN-1:0]       instr_i,
  input  logic [rv_exec_pkg::XLEN-1:0]       pc_i,
  output logic                               wb_valid_o,
  output logic [rv_exec_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv_exec_pkg::XLEN-1:0]       wb_data_o
);

  rv_exec_pkg::decoded_inst_t   dec;
  rv_exec_pkg::ex_wb_t          wb;
  logic [rv_exec_pkg::XLEN-1:0] rdata1;
  logic [rv_exec_pkg::XLEN-1:0] rdata2;

  inst_decoder inst_decoder_inst (
    .instr_i (instr_i),
    .pc_i    (pc_i),
    .dec_o   (dec)
  );

  // the register file is read in the decode cycle and written from writeback.
  reg_file reg_file_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .raddr1_i (dec.rs1),
    .raddr2_i (dec.rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (wb.valid),
    .waddr_i  (wb.rd),
    .wdata_i  (wb.data)
  );

  exec_stage exec_stage_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .dec_i         (dec),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .wb_o          (wb)
  );

  assign wb_valid_o = wb.valid;
  assign wb_rd_o    = wb.rd;
  assign wb_data_o  = wb.data;

endmodule

// File: test/rv_exec_checker.sv
module rv_exec_checker (
  input logic                         clk_i,
  input logic                         arst_n_i,
  input logic                         instr_valid_i,
  input rv_exec_pkg::inst_type_e      inst_type_i,
  input logic                         wb_valid_i,
  input logic [rv_exec_pkg::XLEN-1:0] wb_data_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic accepted;

  assign accepted = instr_valid_i && (inst_type_i != rv_exec_pkg::INST_NOP);

  // the edge that samples reset low has cleared the writeback register.
  reset_clears_wb: assert property (@(posedge clk_i) !arst_n_i |=> !wb_valid_i)
    else $error("writeback valid is set after a reset cycle");

  wb_follows_decode: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_valid_i == $past(accepted, 2))
    else $error("writeback valid does not match the decode two cycles earlier");

  wb_data_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_valid_i |-> !$isunknown(wb_data_i))
    else $error("writeback data has unknown bits");

endmodule

bind rv_exec_top rv_exec_checker rv_exec_checker_inst (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .instr_valid_i (instr_valid_i),
  .inst_type_i   (dec.inst_type),
  .wb_valid_i    (wb_valid_o),
  .wb_data_i     (wb_data_o)
);

// File: test/rv_exec_tb.sv
module rv_exec_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_INSTR     = 3000;
  localparam int WB_TIMEOUT    = 4;
  localparam int DRAIN_TIMEOUT = 16;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_entry_t;

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  logic [31:0] model_regs [0:31];
  wb_entry_t   exp_q [$];
  int unsigned wb_count = 0;

  rv_exec_top rv_exec_top_inst (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .wb_valid_o    (wb_valid),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s: expected 0x%08h, actual 0x%08h",
                         name, expected, actual));
    end
  endtask

  // alt picks SUB for funct3 000 and the arithmetic shift for funct3 101.
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  alu_ref = alt ? a - b : a + b;
      3'b001:  alu_ref = a << b[4:0];
      3'b010:  alu_ref = {31'd0, ($signed(a) < $signed(b))};
      3'b011:  alu_ref = {31'd0, (a < b)};
      3'b100:  alu_ref = a ^ b;
      3'b101: begin
        if (alt) begin
          alu_ref = $signed(a) >>> b[4:0];
        end else begin
          alu_ref = a >> b[4:0];
        end
      end
      3'b110:  alu_ref = a | b;
      default: alu_ref = a & b;
    endcase
  endfunction

  task automatic model_execute(input logic [31:0] word, input logic [31:0] addr);
    wb_entry_t   entry;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic        writes;
    imm_i      = {{20{word[31]}}, word[31:20]};
    imm_u      = {word[31:12], 12'h000};
    entry.rd   = word[11:7];
    entry.data = '0;
    writes     = 1'b1;
    case (word[6:0])
      7'b0110011: begin
        entry.data = alu_ref(word[14:12], word[30], model_regs[word[19:15]],
                             model_regs[word[24:20]]);
      end
      7'b0010011: begin
        entry.data = alu_ref(word[14:12], (word[14:12] == 3'b101) && word[30],
                             model_regs[word[19:15]], imm_i);
      end
      7'b0110111:             entry.data = imm_u;
      7'b0010111:             entry.data = addr + imm_u;
      7'b1101111, 7'b1100111: entry.data = addr + 32'd4;
      default:                writes = 1'b0;
    endcase
    if (writes) begin
      exp_q.push_back(entry);
      if (entry.rd != 5'd0) begin
        model_regs[entry.rd] = entry.data;
      end
    end
  endtask

  // register indices stay within x0 to x7 so that close dependencies are common.
  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [31:0] v;
    logic [2:0]  f3;
    logic        alt;
    logic [6:0]  f7;
    logic [11:0] imm12;
    r     = $urandom();
    v     = $urandom();
    f3    = r[11:9];
    alt   = r[12];
    f7    = {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b00000};
    imm12 = v[11:0];
    if (f3 == 3'b001 || f3 == 3'b101) begin
      imm12 = {1'b0, alt && (f3 == 3'b101), 5'b00000, v[4:0]};
    end
    case ($urandom_range(9, 0))
      0, 1, 2: random_instr = {f7, 2'b00, r[8:6], 2'b00, r[5:3], f3, 2'b00, r[2:0], 7'b0110011};
      3, 4, 5: random_instr = {imm12, 2'b00, r[5:3], f3, 2'b00, r[2:0], 7'b0010011};
      6:       random_instr = {v[31:12], 2'b00, r[2:0], 7'b0110111};
      7:       random_instr = {v[31:12], 2'b00, r[2:0], 7'b0010111};
      8: begin
        if (alt) begin
          random_instr = {v[31:12], 2'b00, r[2:0], 7'b1101111};
        end else begin
          random_instr = {v[11:0], 2'b00, r[5:3], 3'b000, 2'b00, r[2:0], 7'b1100111};
        end
      end
      default: begin
        case (r[14:13])
          2'b00:   random_instr = {v[31:7], 7'b0000011};
          2'b01:   random_instr = {v[31:7], 7'b0100011};
          2'b10:   random_instr = {v[31:7], 7'b1100011};
          default: random_instr = {v[31:7], alt ? 7'b0001111 : 7'b1110011};
        endcase
      end
    endcase
  endfunction

  initial begin
    int unsigned seed_ret;
    logic [31:0] addr;
    seed_ret    = $urandom(32'ha0c7);
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    model_regs  = '{default: '0};
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    repeat (4) @(negedge clk);
    for (int n = 0; n < NUM_INSTR; n++) begin
      @(negedge clk);
      addr        = $urandom();
      pc          = {addr[31:2], 2'b00};
      instr       = random_instr();
      instr_valid = ($urandom_range(3, 0) != 0);
      if (instr_valid) begin
        model_execute(instr, pc);
      end
    end
    @(negedge clk);
    instr_valid = 1'b0;
    for (int c = 0; c < DRAIN_TIMEOUT && exp_q.size() != 0; c++) begin
      @(negedge clk);
    end
    if (exp_q.size() != 0) begin
      fail_run("expected writebacks are still missing after the final drain");
    end else begin
      // a stray writeback in these idle cycles is caught by the monitor.
      repeat (4) @(negedge clk);
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

  // outputs change on the rising edge and are sampled on the falling edge.
  initial begin
    wb_entry_t entry;
    int        idle;
    idle = 0;
    forever begin
      @(negedge clk);
      if (wb_valid) begin
        if (exp_q.size() == 0) begin
          fail_run("a writeback appeared with no instruction outstanding");
        end else begin
          entry = exp_q.pop_front();
          wb_count++;
          idle = 0;
          check_value($sformatf("rd of writeback %0d", wb_count), {27'd0, entry.rd},
                      {27'd0, wb_rd});
          check_value($sformatf("data of writeback %0d", wb_count), entry.data, wb_data);
        end
      end else if (exp_q.size() != 0) begin
        idle++;
        if (idle > WB_TIMEOUT) begin
          fail_run("no writeback arrived for an accepted instruction in time");
        end
      end
    end
  end

endmodule
